/* item_subsystem_top.f */
verilog/item_pkg.sv
verilog/lfsr_pbit.sv
verilog/spawn_decode.sv
verilog/player_tile_map.sv
verilog/item_timer.sv
verilog/pickup_result.sv
verilog/item_subsystem_top.sv
tests/item_subsystem_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the item subsystem testbench with Verilator and run it
# the run passes only when the simulation output holds the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module item_subsystem_tb \
    -f item_subsystem_top.f \
    -o item_sim \
    && ./obj_dir/item_sim | tee /dev/stderr | grep -F '** PASS **' > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

/* tests/item_subsystem_tb.sv */
`timescale 1ns/100ps

module item_subsystem_tb;

    localparam int CLK_HALF  = 4;                     // 8 ns period
    localparam int PARK_X    = 2000;                  // feet land in column 31 off the map
    localparam int LIFE_TICK = item_pkg::TICKS_PER_SEC * item_pkg::ITEM_SECONDS;

    logic                  clk;
    logic                  arst_n;
    logic                  tick;
    logic                  game_over;
    logic                  map_we;
    item_pkg::tile_addr_t  map_addr;
    item_pkg::tile_code_t  map_data;
    item_pkg::prob_t       probability;
    item_pkg::pos_x_t      p1_x;
    item_pkg::pos_y_t      p1_y;
    item_pkg::pos_x_t      p2_x;
    item_pkg::pos_y_t      p2_y;
    logic                  item_active;
    item_pkg::tile_addr_t  item_addr;
    logic                  player_1_on_item;
    logic                  player_2_on_item;
    logic                  pickup_pulse;
    item_pkg::pickup_cnt_t p1_pickups;
    item_pkg::pickup_cnt_t p2_pickups;

    int          err_count;
    int          test_count;
    int          test_start_errs;
    int          cycles;
    int          exp_p1;                              // expected player 1 pickups
    int          exp_p2;                              // expected player 2 pickups
    bit          found;
    int          addr_a;
    int          addr_b;

    item_subsystem_top UUT (.*);

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    // --------------------------------------------------
    // helpers
    // --------------------------------------------------
    task automatic check_value(input string name, input int expected, input int actual);
        if (expected != actual) begin
            err_count++;
            $display("** Error %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic report_timeout(input string what);
        err_count++;
        $display("timeout: %s", what);
    endtask

    task automatic flag_failure(input string what);
        err_count++;
        $display("%s", what);
    endtask

    task automatic begin_test();
        test_start_errs = err_count;
    endtask

    task automatic end_test(input string name);
        test_count++;
        if (err_count == test_start_errs) $display("test %s: ok", name);
        else $display("test %s: %0d errors", name, err_count - test_start_errs);
    endtask

    // one write strobe driven between rising edges
    task automatic drive_map_write(input int addr, input int data);
        @(negedge clk);
        map_we   = 1'b1;
        map_addr = item_pkg::tile_addr_t'(addr);
        map_data = item_pkg::tile_code_t'(data);
        @(negedge clk);
        map_we   = 1'b0;                              // sampled exactly once
    endtask

    task automatic wait_item_level(input logic level, input int max_cycles,
                                   output bit hit, output int n);
        hit = 1'b0;
        n   = 0;
        while (!hit && n < max_cycles) begin
            @(negedge clk);
            n++;
            if (item_active == level) hit = 1'b1;
        end
    endtask

    task automatic wait_pickup(input int max_cycles, output bit hit);
        int n;
        hit = 1'b0;
        n   = 0;
        while (!hit && n < max_cycles) begin
            @(negedge clk);
            n++;
            if (pickup_pulse) hit = 1'b1;
        end
    endtask

    // left foot column is x >> 6 with a random spot inside the tile
    function automatic item_pkg::pos_x_t place_x_on_tile(input int addr);
        return item_pkg::pos_x_t'((addr % item_pkg::NUM_COL) * item_pkg::TILE_PX
                                  + ($urandom % item_pkg::TILE_PX));
    endfunction

    // foot row is (y + 47) >> 6 so y + 47 has to stay inside the tile row
    function automatic item_pkg::pos_y_t place_y_on_tile(input int addr);
        return item_pkg::pos_y_t'((addr / item_pkg::NUM_COL) * item_pkg::TILE_PX
                                  + ($urandom % (item_pkg::TILE_PX - item_pkg::SPRITE_H + 1)));
    endfunction

    task automatic park_players();
        p1_x = item_pkg::pos_x_t'(PARK_X);
        p1_y = '0;
        p2_x = item_pkg::pos_x_t'(PARK_X);
        p2_y = '0;
    endtask

    // --------------------------------------------------
    // checking assertions
    // --------------------------------------------------
    a_zero_prob : assert property (@(posedge clk) disable iff (!arst_n)
        $rose(item_active) |-> ($past(probability, 3) != 32'd0))
        else flag_failure("item appeared while probability was zero");

    a_pulse_flags : assert property (@(posedge clk) disable iff (!arst_n)
        pickup_pulse == (player_1_on_item || player_2_on_item))
        else flag_failure("pickup pulse does not match the on-item flags");

    a_pulse_ends_item : assert property (@(posedge clk) disable iff (!arst_n)
        pickup_pulse |=> !item_active)
        else flag_failure("item stayed active after a pickup");

    a_game_over_clears : assert property (@(posedge clk) disable iff (!arst_n)
        game_over |=> !item_active)
        else flag_failure("game over left the item active");

    a_flags_need_item : assert property (@(posedge clk) disable iff (!arst_n)
        (player_1_on_item || player_2_on_item) |-> $past(item_active))
        else flag_failure("on-item flag raised without an item");

    // counters never fall, not even on game over
    a_counts_climb : assert property (@(posedge clk) disable iff (!arst_n)
        (p1_pickups >= $past(p1_pickups)) && (p2_pickups >= $past(p2_pickups)))
        else flag_failure("a pickup counter went down");

    // hard stop in case a loop above is broken
    initial begin
        #2_000_000;
        $display("simulation ran past its time limit");
        $display("** FAIL **");
        $finish;
    end

    // --------------------------------------------------
    // stimulus
    // --------------------------------------------------
    initial begin
        arst_n      = 1'b0;
        tick        = 1'b0;
        game_over   = 1'b0;
        map_we      = 1'b0;
        map_addr    = '0;
        map_data    = '0;
        probability = '0;
        park_players();
        err_count   = 0;
        test_count  = 0;
        exp_p1      = 0;
        exp_p2      = 0;
        void'($urandom(72));                          // one seed for the whole run
        repeat (4) @(negedge clk);
        arst_n = 1'b1;

        begin_test();                                 // reset values
        @(negedge clk);
        check_value("reset item_active", 0, int'(item_active));
        check_value("reset item_addr", 0, int'(item_addr));
        check_value("reset p1 on item", 0, int'(player_1_on_item));
        check_value("reset p2 on item", 0, int'(player_2_on_item));
        check_value("reset pickup_pulse", 0, int'(pickup_pulse));
        check_value("reset p1_pickups", 0, int'(p1_pickups));
        check_value("reset p2_pickups", 0, int'(p2_pickups));
        end_test("reset");

        begin_test();                                 // probability zero
        for (int i = 0; i < 20; i++) drive_map_write((i * 11) % item_pkg::DEPTH, 0);
        repeat (4) @(negedge clk);
        check_value("zero probability item_active", 0, int'(item_active));
        end_test("zero_probability");

        begin_test();                                 // spawn and filter
        probability = '1;
        drive_map_write(40, 2);                       // block written instead of cleared
        repeat (3) @(negedge clk);
        check_value("nonzero data item_active", 0, int'(item_active));
        drive_map_write(item_pkg::DEPTH, 0);          // first address past the map
        repeat (3) @(negedge clk);
        check_value("off map item_active", 0, int'(item_active));
        addr_a = 57;
        drive_map_write(addr_a, 0);                   // strobe ends one cycle after its edge
        @(negedge clk);
        check_value("spawn latency item_active", 0, int'(item_active));
        @(negedge clk);
        check_value("spawn item_active", 1, int'(item_active));
        check_value("spawn item_addr", addr_a, int'(item_addr));
        drive_map_write(120, 0);                      // dropped while the first item lives
        repeat (3) @(negedge clk);
        check_value("second clear item_addr", addr_a, int'(item_addr));
        end_test("spawn_filter");

        begin_test();                                 // expiry of the live item
        @(negedge clk);
        tick = 1'b1;
        wait_item_level(1'b0, LIFE_TICK + 100, found, cycles);
        tick = 1'b0;
        if (!found) report_timeout("item never expired");
        else if (cycles < LIFE_TICK - 1 || cycles > LIFE_TICK + 2)
            check_value("expiry ticks", LIFE_TICK, cycles);
        end_test("expiry");

        begin_test();                                 // pickup by player 2 and then by both
        addr_a = int'($urandom % item_pkg::DEPTH);
        drive_map_write(addr_a, 0);
        wait_item_level(1'b1, 10, found, cycles);
        if (!found) report_timeout("item for player 2 never appeared");
        p2_x = place_x_on_tile(addr_a);
        p2_y = place_y_on_tile(addr_a);
        exp_p2++;
        wait_pickup(10, found);
        if (!found) report_timeout("player 2 never picked up the item");
        check_value("p2 on item", 1, int'(player_2_on_item));
        check_value("p1 on item", 0, int'(player_1_on_item));
        check_value("p2 count after pickup", exp_p2, int'(p2_pickups));
        @(negedge clk);
        check_value("item_active after pickup", 0, int'(item_active));
        check_value("p1 count unchanged", exp_p1, int'(p1_pickups));
        park_players();

        addr_b = int'($urandom % item_pkg::DEPTH);
        drive_map_write(addr_b, 0);
        wait_item_level(1'b1, 10, found, cycles);
        if (!found) report_timeout("item for both players never appeared");
        p1_x = place_x_on_tile(addr_b);               // both step on in the same cycle
        p1_y = place_y_on_tile(addr_b);
        p2_x = place_x_on_tile(addr_b);
        p2_y = place_y_on_tile(addr_b);
        exp_p1++;
        exp_p2++;
        wait_pickup(10, found);
        if (!found) report_timeout("shared pickup never happened");
        check_value("shared p1 on item", 1, int'(player_1_on_item));
        check_value("shared p2 on item", 1, int'(player_2_on_item));
        check_value("shared p1 count", exp_p1, int'(p1_pickups));
        check_value("shared p2 count", exp_p2, int'(p2_pickups));
        park_players();
        end_test("pickup");

        begin_test();                                 // game over ends the item
        drive_map_write(int'($urandom % item_pkg::DEPTH), 0);
        wait_item_level(1'b1, 10, found, cycles);
        if (!found) report_timeout("item before game over never appeared");
        game_over = 1'b1;
        @(negedge clk);
        game_over = 1'b0;
        check_value("game over item_active", 0, int'(item_active));
        check_value("game over p1 count", exp_p1, int'(p1_pickups));
        check_value("game over p2 count", exp_p2, int'(p2_pickups));
        end_test("game_over");

        repeat (2) @(negedge clk);
        $display("tests run: %0d, errors: %0d", test_count, err_count);
        if (err_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* verilog/item_pkg.sv */
package item_pkg;

    // --------------------------------------------------
    // map geometry
    // --------------------------------------------------
    localparam int NUM_ROW    = 11;                   // tile rows
    localparam int NUM_COL    = 19;                   // tile columns
    localparam int DEPTH      = NUM_ROW * NUM_COL;    // 209 tiles
    localparam int ADDR_W     = $clog2(DEPTH);        // 8 bits
    localparam int TILE_PX    = 64;                   // pixels per tile edge
    localparam int TILE_SHIFT = $clog2(TILE_PX);      // pixel -> tile index
    localparam int SPRITE_W   = 32;                   // player sprite width
    localparam int SPRITE_H   = 48;                   // player sprite height

    // --------------------------------------------------
    // item timing
    // --------------------------------------------------
    localparam int TICKS_PER_SEC = 60;                // frame ticks per second
    localparam int ITEM_SECONDS  = 8;                 // 480 ticks lifetime
    localparam int TICK_W        = $clog2(TICKS_PER_SEC);
    localparam int SEC_W         = $clog2(ITEM_SECONDS + 1);

    // pickup counter width, saturates at all ones
    localparam int COUNT_W = 4;

    // random source, x^32 + x^22 + x^2 + x + 1 in right shift form
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;
    localparam logic [31:0] LFSR_SEED = 32'hACE1_2B57; // any nonzero value

    // --------------------------------------------------
    // vector types
    // --------------------------------------------------
    typedef logic [ADDR_W-1:0]  tile_addr_t;          // linear map address
    typedef logic [1:0]         tile_code_t;          // map tile content
    typedef logic [10:0]        pos_x_t;              // pixel column
    typedef logic [9:0]         pos_y_t;              // pixel row
    typedef logic [31:0]        prob_t;               // spawn threshold
    typedef logic [COUNT_W-1:0] pickup_cnt_t;         // per player pickups
    typedef logic [TICK_W-1:0]  tick_cnt_t;           // 0 .. 59
    typedef logic [SEC_W-1:0]   sec_cnt_t;            // ITEM_SECONDS .. 1

    localparam tile_code_t TILE_EMPTY = 2'd0;         // cleared block

    // item lifecycle
    typedef enum logic {
        ITEM_IDLE,
        ITEM_ACTIVE
    } item_state_t;

endpackage

/* verilog/item_subsystem_top.sv */
`timescale 1ns/100ps

module item_subsystem_top (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  tick,
    input  logic                  game_over,
    input  logic                  map_we,
    input  item_pkg::tile_addr_t  map_addr,
    input  item_pkg::tile_code_t  map_data,
    input  item_pkg::prob_t       probability,
    input  item_pkg::pos_x_t      p1_x,
    input  item_pkg::pos_y_t      p1_y,
    input  item_pkg::pos_x_t      p2_x,
    input  item_pkg::pos_y_t      p2_y,
    output logic                  item_active,
    output item_pkg::tile_addr_t  item_addr,
    output logic                  player_1_on_item,
    output logic                  player_2_on_item,
    output logic                  pickup_pulse,
    output item_pkg::pickup_cnt_t p1_pickups,
    output item_pkg::pickup_cnt_t p2_pickups
);

    // --------------------------------------------------
    // stage wiring
    // --------------------------------------------------
    logic                 spawn_valid;   // decode -> timer
    item_pkg::tile_addr_t spawn_addr;
    item_pkg::tile_addr_t p1_addr_l, p1_addr_r;   // mappers -> result
    item_pkg::tile_addr_t p2_addr_l, p2_addr_r;
    logic                 p1_valid_l, p1_valid_r;
    logic                 p2_valid_l, p2_valid_r;

    spawn_decode u_spawn (
        .clk (clk), .arst_n (arst_n), .game_over (game_over),
        .map_we (map_we), .map_addr (map_addr), .map_data (map_data),
        .probability (probability),
        .spawn_valid (spawn_valid), .spawn_addr (spawn_addr)
    );

    item_timer u_timer (
        .clk (clk), .arst_n (arst_n), .tick (tick), .game_over (game_over),
        .spawn_valid (spawn_valid), .spawn_addr (spawn_addr),
        .pickup_pulse (pickup_pulse),
        .item_active (item_active), .item_addr (item_addr)
    );

    player_tile_map p1_tiles (
        .clk (clk), .arst_n (arst_n), .pos_x (p1_x), .pos_y (p1_y),
        .foot_addr_l (p1_addr_l), .foot_addr_r (p1_addr_r),
        .foot_valid_l (p1_valid_l), .foot_valid_r (p1_valid_r)
    );

    player_tile_map p2_tiles (
        .clk (clk), .arst_n (arst_n), .pos_x (p2_x), .pos_y (p2_y),
        .foot_addr_l (p2_addr_l), .foot_addr_r (p2_addr_r),
        .foot_valid_l (p2_valid_l), .foot_valid_r (p2_valid_r)
    );

    pickup_result u_result (
        .clk (clk), .arst_n (arst_n),
        .item_active (item_active), .item_addr (item_addr),
        .p1_addr_l (p1_addr_l), .p1_addr_r (p1_addr_r),
        .p2_addr_l (p2_addr_l), .p2_addr_r (p2_addr_r),
        .p1_valid_l (p1_valid_l), .p1_valid_r (p1_valid_r),
        .p2_valid_l (p2_valid_l), .p2_valid_r (p2_valid_r),
        .player_1_on_item (player_1_on_item), .player_2_on_item (player_2_on_item),
        .pickup_pulse (pickup_pulse),
        .p1_pickups (p1_pickups), .p2_pickups (p2_pickups)
    );

endmodule

/* verilog/item_timer.sv */
`timescale 1ns/100ps

module item_timer (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 tick,
    input  logic                 game_over,
    input  logic                 spawn_valid,
    input  item_pkg::tile_addr_t spawn_addr,
    input  logic                 pickup_pulse,
    output logic                 item_active,
    output item_pkg::tile_addr_t item_addr
);

    item_pkg::item_state_t state_q;
    item_pkg::item_state_t state_d;

    item_pkg::tick_cnt_t tick_cnt;    // ticks inside current second
    item_pkg::sec_cnt_t  sec_left;    // seconds remaining

    logic last_tick;                  // tick that closes a second
    logic expire;                     // tick that closes the last second
    logic start;                      // accepted spawn

    assign last_tick = tick && (tick_cnt ==
                       item_pkg::tick_cnt_t'(item_pkg::TICKS_PER_SEC - 1));
    assign expire    = last_tick && (sec_left == item_pkg::sec_cnt_t'(1));
    assign start     = (state_q == item_pkg::ITEM_IDLE) && spawn_valid;

    // --------------------------------------------------
    // next state
    // --------------------------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            item_pkg::ITEM_IDLE: begin
                if (spawn_valid) begin
                    state_d = item_pkg::ITEM_ACTIVE;
                end
            end
            item_pkg::ITEM_ACTIVE: begin
                // pickup or timeout ends it, spawns are ignored here
                if (pickup_pulse || expire) begin
                    state_d = item_pkg::ITEM_IDLE;
                end
            end
            default: state_d = item_pkg::ITEM_IDLE;
        endcase
        if (game_over) begin
            state_d = item_pkg::ITEM_IDLE;            // wins over everything
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= item_pkg::ITEM_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // --------------------------------------------------
    // saved address and lifetime counters
    // --------------------------------------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            item_addr <= '0;
            tick_cnt  <= '0;
            sec_left  <= item_pkg::sec_cnt_t'(item_pkg::ITEM_SECONDS);
        end else if (start && !game_over) begin
            item_addr <= spawn_addr;                  // latched once per item
            tick_cnt  <= '0;
            sec_left  <= item_pkg::sec_cnt_t'(item_pkg::ITEM_SECONDS);
        end else if (state_q == item_pkg::ITEM_ACTIVE && tick) begin
            if (last_tick) begin
                tick_cnt <= '0;
                sec_left <= sec_left - item_pkg::sec_cnt_t'(1);
            end else begin
                tick_cnt <= tick_cnt + item_pkg::tick_cnt_t'(1);
            end
        end
    end

    assign item_active = (state_q == item_pkg::ITEM_ACTIVE);

    // pickup compare downstream assumes a fixed target for the whole life
    a_addr_stable : assert property (
        @(posedge clk) disable iff (!arst_n)
        (item_active && $past(item_active)) |-> $stable(item_addr)
    );

    // a spawn landing on a live item is dropped, not retargeted
    a_spawn_dropped : assert property (
        @(posedge clk) disable iff (!arst_n)
        (item_active && spawn_valid) |=> (item_addr == $past(item_addr))
    );

endmodule

/* verilog/lfsr_pbit.sv */
`timescale 1ns/100ps

module lfsr_pbit (
    input  logic           clk,
    input  logic           arst_n,
    input  item_pkg::prob_t probability,
    output logic           rand_bit
);

    // --------------------------------------------------
    // galois lfsr stepping once per cycle
    // --------------------------------------------------
    logic [31:0] lfsr_q;
    logic [31:0] lfsr_d;

    // shift right and fold taps back in when a one falls out
    always_comb begin
        lfsr_d = lfsr_q >> 1;
        if (lfsr_q[0]) begin
            lfsr_d = lfsr_d ^ item_pkg::LFSR_TAPS;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lfsr_q <= item_pkg::LFSR_SEED;            // never zero
        end else begin
            lfsr_q <= lfsr_d;
        end
    end

    // --------------------------------------------------
    // threshold compare
    // --------------------------------------------------
    // state sweeps 1 .. 2^32-1 uniformly so p(1) ~ probability / 2^32
    // probability 0 never fires and all ones always fires
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rand_bit <= 1'b0;
        end else begin
            rand_bit <= (lfsr_q <= probability);
        end
    end

endmodule

/* verilog/pickup_result.sv */
`timescale 1ns/100ps

module pickup_result (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  item_active,
    input  item_pkg::tile_addr_t  item_addr,
    input  item_pkg::tile_addr_t  p1_addr_l,
    input  item_pkg::tile_addr_t  p1_addr_r,
    input  item_pkg::tile_addr_t  p2_addr_l,
    input  item_pkg::tile_addr_t  p2_addr_r,
    input  logic                  p1_valid_l,
    input  logic                  p1_valid_r,
    input  logic                  p2_valid_l,
    input  logic                  p2_valid_r,
    output logic                  player_1_on_item,
    output logic                  player_2_on_item,
    output logic                  pickup_pulse,
    output item_pkg::pickup_cnt_t p1_pickups,
    output item_pkg::pickup_cnt_t p2_pickups
);

    logic armed;     // item live and not already taken this cycle
    logic hit_1;
    logic hit_2;

    // --------------------------------------------------
    // foot match
    // --------------------------------------------------
    // timer still shows active one cycle after the pulse, mask that cycle
    assign armed = item_active && !pickup_pulse;
    assign hit_1 = armed && ((p1_valid_l && (p1_addr_l == item_addr)) ||
                             (p1_valid_r && (p1_addr_r == item_addr)));
    assign hit_2 = armed && ((p2_valid_l && (p2_addr_l == item_addr)) ||
                             (p2_valid_r && (p2_addr_r == item_addr)));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            player_1_on_item <= 1'b0;
            player_2_on_item <= 1'b0;
            pickup_pulse     <= 1'b0;
        end else begin
            player_1_on_item <= hit_1;
            player_2_on_item <= hit_2;
            pickup_pulse     <= hit_1 || hit_2;   // either player takes it
        end
    end

    // --------------------------------------------------
    // saturating counters, both credited on a tie
    // --------------------------------------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            p1_pickups <= '0;
            p2_pickups <= '0;
        end else begin
            if (hit_1 && (p1_pickups != '1)) p1_pickups <= p1_pickups + 1'b1;
            if (hit_2 && (p2_pickups != '1)) p2_pickups <= p2_pickups + 1'b1;
        end
    end

    // one pulse per item, relies on the timer dropping active right after
    a_pulse_single : assert property (
        @(posedge clk) disable iff (!arst_n)
        pickup_pulse |=> !pickup_pulse
    );

endmodule

/* verilog/player_tile_map.sv */
`timescale 1ns/100ps

module player_tile_map (
    input  logic                 clk,
    input  logic                 arst_n,
    input  item_pkg::pos_x_t     pos_x,
    input  item_pkg::pos_y_t     pos_y,
    output item_pkg::tile_addr_t foot_addr_l,
    output item_pkg::tile_addr_t foot_addr_r,
    output logic                 foot_valid_l,
    output logic                 foot_valid_r
);

    // --------------------------------------------------
    // foot pixels
    // --------------------------------------------------
    logic [10:0] foot_y;       // bottom sprite row, one bit of headroom
    logic [11:0] foot_x_l;     // left edge
    logic [11:0] foot_x_r;     // right edge, may pass 2047

    logic [4:0]  row;          // shared by both feet
    logic [5:0]  col_l;
    logic [5:0]  col_r;

    logic [9:0]  lin_l;        // row * NUM_COL + col, before bounds
    logic [9:0]  lin_r;
    logic        row_ok;
    logic        ok_l;
    logic        ok_r;

    assign foot_y   = 11'(pos_y) + 11'(item_pkg::SPRITE_H - 1);
    assign foot_x_l = 12'(pos_x);
    assign foot_x_r = 12'(pos_x) + 12'(item_pkg::SPRITE_W - 1);

    // pixel -> tile index
    assign row   = 5'(foot_y >> item_pkg::TILE_SHIFT);
    assign col_l = 6'(foot_x_l >> item_pkg::TILE_SHIFT);
    assign col_r = 6'(foot_x_r >> item_pkg::TILE_SHIFT);

    // --------------------------------------------------
    // bounds and linear address
    // --------------------------------------------------
    assign row_ok = (row < 5'(item_pkg::NUM_ROW));
    assign ok_l   = row_ok && (col_l < 6'(item_pkg::NUM_COL));
    assign ok_r   = row_ok && (col_r < 6'(item_pkg::NUM_COL));

    // max in-map value is 208, low ADDR_W bits are enough when ok
    assign lin_l = 10'(row) * 10'(item_pkg::NUM_COL) + 10'(col_l);
    assign lin_r = 10'(row) * 10'(item_pkg::NUM_COL) + 10'(col_r);

    // valid bits reset, addresses only mean something when valid
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            foot_valid_l <= 1'b0;
            foot_valid_r <= 1'b0;
        end else begin
            foot_valid_l <= ok_l;
            foot_valid_r <= ok_r;
        end
    end

    always_ff @(posedge clk) begin
        foot_addr_l <= lin_l[item_pkg::ADDR_W-1:0];
        foot_addr_r <= lin_r[item_pkg::ADDR_W-1:0];
    end

endmodule

/* verilog/spawn_decode.sv */
`timescale 1ns/100ps

module spawn_decode (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 game_over,
    input  logic                 map_we,
    input  item_pkg::tile_addr_t map_addr,
    input  item_pkg::tile_code_t map_data,
    input  item_pkg::prob_t      probability,
    output logic                 spawn_valid,
    output item_pkg::tile_addr_t spawn_addr
);

    logic                 rand_bit;   // one roll per cycle
    logic                 we_q;       // sampled write strobe
    item_pkg::tile_addr_t addr_q;     // sampled write address
    item_pkg::tile_code_t data_q;     // sampled write data
    logic                 clear_hit;  // write that empties an on-map tile
    logic                 spawn_hit;  // clear that also won the roll

    lfsr_pbit u_pbit (
        .clk         (clk),
        .arst_n      (arst_n),
        .probability (probability),
        .rand_bit    (rand_bit)
    );

    // --------------------------------------------------
    // map write sample stage
    // --------------------------------------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            we_q <= 1'b0;
        end else if (game_over) begin
            we_q <= 1'b0;                      // round over drops the sampled write
        end else begin
            we_q <= map_we;
        end
    end

    always_ff @(posedge clk) begin
        addr_q <= map_addr;
        data_q <= map_data;
    end

    // --------------------------------------------------
    // write qualification
    // --------------------------------------------------
    // only block -> empty writes count, and only inside the map
    assign clear_hit = we_q
                    && (data_q == item_pkg::TILE_EMPTY)
                    && (addr_q < item_pkg::tile_addr_t'(item_pkg::DEPTH));
    assign spawn_hit = clear_hit && rand_bit;

    // one cycle wide request flag
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            spawn_valid <= 1'b0;
        end else if (game_over) begin
            spawn_valid <= 1'b0;               // round over drops the pending request
        end else begin
            spawn_valid <= spawn_hit;
        end
    end

    // address travels with the flag
    always_ff @(posedge clk) begin
        if (spawn_hit) begin
            spawn_addr <= addr_q;
        end
    end

    // downstream relies on this range check
    a_spawn_in_map : assert property (
        @(posedge clk) disable iff (!arst_n)
        spawn_valid |-> (spawn_addr < item_pkg::tile_addr_t'(item_pkg::DEPTH))
    );

endmodule
